/* hw/readout_pkg.sv */
package readout_pkg;

  //////////////////////////////////////////////////////////////////////
  // stream widths
  //////////////////////////////////////////////////////////////////////

  localparam int burst_width     = 128;              // one memory burst from the reader
  localparam int link_width      = 32;               // one word on the transmit link
  localparam int words_per_burst = burst_width / link_width;  // 4 link words per burst
  localparam int word_sel_width  = 2;                // index of a word inside a burst

  //////////////////////////////////////////////////////////////////////
  // fill readout sequencing
  //////////////////////////////////////////////////////////////////////

  // the link carries command responses in fill_idle and fill_drain_cmd
  // and carries fill data only in fill_send
  typedef enum logic [1:0] {
    fill_idle      = 2'd0,   // command responses own the link
    fill_drain_cmd = 2'd1,   // fill requested, waiting for the open command frame to end
    fill_send      = 2'd2    // fill data owns the link until its last word
  } fill_state_e;

endpackage

/* hw/burst_fifo.sv */
`timescale 1ns/1ps

module burst_fifo #(
  parameter int fifo_depth        = 16,    // number of bursts held
  parameter int almost_full_level = 12     // count at which almost_full rises
) (
  input  logic                            clk125,
  input  logic                            rst_n,
  input  logic [readout_pkg::burst_width-1:0] wr_data,   // burst from the memory reader
  input  logic                            wr_last,       // final burst of a fill
  input  logic                            wr_en,         // write strobe, no ready
  input  logic                            rd_ready,      // converter takes the head burst
  output logic [readout_pkg::burst_width-1:0] rd_data,   // head burst
  output logic                            rd_last,       // last flag of the head burst
  output logic                            rd_valid,      // head burst present
  output logic                            almost_full    // registered, tells the reader to stop
);
  import readout_pkg::*;

  localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
  localparam int cnt_width = $clog2(fifo_depth + 1);

  logic [burst_width-1:0] data_mem [fifo_depth];   // burst storage
  logic                   last_mem [fifo_depth];   // last flag per entry
  logic [ptr_width-1:0]   wr_ptr;
  logic [ptr_width-1:0]   rd_ptr;
  logic [cnt_width-1:0]   count;                   // occupancy
  logic                   full;
  logic                   wr_ok;                   // write actually stored
  logic                   rd_ok;                   // head actually removed

  assign full     = (count == cnt_width'(fifo_depth));
  assign wr_ok    = wr_en && !full;               // write into a full fifo is dropped
  assign rd_valid = (count != '0);
  assign rd_ok    = rd_valid && rd_ready;
  assign rd_data  = data_mem[rd_ptr];              // head shows the cycle after its write
  assign rd_last  = last_mem[rd_ptr];

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk125) begin
    if (wr_ok) begin
      data_mem[wr_ptr] <= wr_data;
      last_mem[wr_ptr] <= wr_last;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointers, count and almost-full flag
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      almost_full <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;  // wrap
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                   // none or both
      endcase
      almost_full <= (count >= cnt_width'(almost_full_level));  // one cycle behind count
    end
  end

endmodule

/* hw/burst_width_converter.sv */
`timescale 1ns/1ps

module burst_width_converter (
  input  logic                                clk125,
  input  logic                                rst_n,
  input  logic [readout_pkg::burst_width-1:0] burst_data,   // head burst from the fifo
  input  logic                                burst_last,   // burst ends a fill
  input  logic                                burst_valid,
  input  logic                                word_ready,   // mux takes the current word
  output logic                                burst_ready,  // converter loads a burst
  output logic [readout_pkg::link_width-1:0]  word_data,
  output logic                                word_last,    // last word of the fill
  output logic                                word_valid
);
  import readout_pkg::*;

  localparam logic [word_sel_width-1:0] last_sel = word_sel_width'(words_per_burst - 1);

  logic [burst_width-1:0]    burst_q;    // burst being sent
  logic                      last_q;     // held burst is the final one
  logic [word_sel_width-1:0] word_sel;   // word being presented, lsw first
  logic                      word_fire;  // word accepted this cycle
  logic                      load;       // burst taken this cycle

  assign word_fire   = word_valid && word_ready;
  // empty, or about to hand over the last word of the held burst
  assign burst_ready = !word_valid || (word_fire && (word_sel == last_sel));
  assign load        = burst_ready && burst_valid;

  assign word_data = burst_q[word_sel * link_width +: link_width];
  assign word_last = last_q && (word_sel == last_sel);   // only word 3 of a last burst

  //////////////////////////////////////////////////////////////////////
  // payload register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk125) begin
    if (load) begin
      burst_q <= burst_data;
      last_q  <= burst_last;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // word sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      word_valid <= 1'b0;
      word_sel   <= '0;
    end else if (load) begin
      word_valid <= 1'b1;             // next burst follows with no gap
      word_sel   <= '0;
    end else if (word_fire) begin
      if (word_sel == last_sel) begin
        word_valid <= 1'b0;           // fifo was empty, go idle
        word_sel   <= '0;
      end else begin
        word_sel <= word_sel + 1'b1;  // step to next word
      end
    end
  end

endmodule

/* hw/fill_readout_ctrl.sv */
`timescale 1ns/1ps

module fill_readout_ctrl (
  input  logic clk125,
  input  logic rst_n,
  input  logic fill_start,     // one-cycle request from the master
  input  logic cmd_accept,     // command beat went out on the link
  input  logic fill_accept,    // fill word went out on the link
  input  logic accept_last,    // accepted beat carried last
  output logic use_fill_data,  // link source select to the mux
  output logic reading_done,   // pulse after the last fill word
  output logic fill_busy       // a fill is pending or being sent
);
  import readout_pkg::*;

  fill_state_e state;
  fill_state_e state_next;
  logic        cmd_open;        // command frame started but not finished
  logic        cmd_open_next;   // includes this cycle's accepted beat
  logic        fill_end;        // last fill word accepted

  assign cmd_open_next = cmd_accept ? !accept_last : cmd_open;
  assign fill_end      = (state == fill_send) && fill_accept && accept_last;

  assign use_fill_data = (state == fill_send);
  assign fill_busy     = (state != fill_idle);

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      fill_idle: begin
        if (fill_start) begin
          state_next = cmd_open_next ? fill_drain_cmd : fill_send;  // never cut a frame
        end
      end
      fill_drain_cmd: begin
        if (cmd_accept && accept_last) begin
          state_next = fill_send;     // switch right after the closing beat
        end
      end
      fill_send: begin
        if (fill_end) begin
          state_next = fill_idle;
        end
      end
      default: state_next = fill_idle;
    endcase
  end

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      state        <= fill_idle;
      cmd_open     <= 1'b0;
      reading_done <= 1'b0;
    end else begin
      state        <= state_next;
      cmd_open     <= cmd_open_next;
      reading_done <= fill_end;      // one cycle after the last word
    end
  end

endmodule

/* hw/link_tx_mux.sv */
`timescale 1ns/1ps

module link_tx_mux (
  input  logic                               clk125,
  input  logic                               rst_n,
  input  logic                               readout_pause,  // async level from the master
  input  logic                               use_fill_data,  // 1 selects the fill stream
  input  logic [readout_pkg::link_width-1:0] cmd_data,
  input  logic                               cmd_valid,
  input  logic                               cmd_last,
  input  logic [readout_pkg::link_width-1:0] fill_data,
  input  logic                               fill_valid,
  input  logic                               fill_last,
  input  logic                               tx_ready,
  output logic                               cmd_ready,
  output logic                               fill_ready,
  output logic [readout_pkg::link_width-1:0] tx_data,
  output logic                               tx_valid,
  output logic                               tx_last,
  output logic                               cmd_accept,     // command beat transferred
  output logic                               fill_accept,    // fill word transferred
  output logic                               accept_last     // transferred beat had last
);

  logic pause_s1;     // first sync stage
  logic pause_s2;     // synchronized pause
  logic link_ready;   // link takes a beat when not paused

  //////////////////////////////////////////////////////////////////////
  // pause synchronizer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      pause_s1 <= 1'b1;               // link comes out of reset paused
      pause_s2 <= 1'b1;
    end else begin
      pause_s1 <= readout_pause;
      pause_s2 <= pause_s1;
    end
  end

  assign link_ready = tx_ready && !pause_s2;

  assign tx_data  = use_fill_data ? fill_data : cmd_data;
  assign tx_last  = use_fill_data ? fill_last : cmd_last;
  assign tx_valid = (use_fill_data ? fill_valid : cmd_valid) && !pause_s2;

  assign fill_ready = use_fill_data && link_ready;    // inactive source sees ready low
  assign cmd_ready  = !use_fill_data && link_ready;

  assign fill_accept = fill_valid && fill_ready;
  assign cmd_accept  = cmd_valid && cmd_ready;
  assign accept_last = tx_last;

endmodule

/* hw/status_led.sv */
`timescale 1ns/1ps

module status_led #(
  parameter int blink_bit = 22          // counter bit that drives the blink
) (
  input  logic clk125,
  input  logic rst_n,
  input  logic link_up,                 // serial link is up
  input  logic fill_busy,               // fill readout in progress
  output logic red_led,
  output logic green_led
);

  logic [blink_bit:0] blink_cnt;        // free-running, top bit is the blink

  //////////////////////////////////////////////////////////////////////
  // blink counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      blink_cnt <= '0;
    end else begin
      blink_cnt <= blink_cnt + 1'b1;    // wraps freely
    end
  end

  //////////////////////////////////////////////////////////////////////
  // led drive
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      red_led   <= 1'b0;
      green_led <= 1'b0;
    end else begin
      red_led <= !link_up;              // red means no link
      if (!link_up) begin
        green_led <= 1'b0;
      end else if (fill_busy) begin
        green_led <= blink_cnt[blink_bit];  // blinks during readout
      end else begin
        green_led <= 1'b1;              // steady when idle
      end
    end
  end

endmodule

/* hw/channel_readout_top.sv */
`timescale 1ns/1ps

module channel_readout_top #(
  parameter int fifo_depth        = 16,   // bursts in the read fifo
  parameter int almost_full_level = 12,   // throttle point for the memory reader
  parameter int blink_bit         = 22    // led blink rate
) (
  input  logic                                clk125,
  input  logic                                rst_n,
  // memory reader
  input  logic [readout_pkg::burst_width-1:0] mem_data,
  input  logic                                mem_valid,
  input  logic                                mem_last,
  output logic                                mem_almost_full,
  // command responses
  input  logic [readout_pkg::link_width-1:0]  cmd_data,
  input  logic                                cmd_valid,
  input  logic                                cmd_last,
  output logic                                cmd_ready,
  // link transmit
  output logic [readout_pkg::link_width-1:0]  tx_data,
  output logic                                tx_valid,
  output logic                                tx_last,
  input  logic                                tx_ready,
  // controls and status
  input  logic                                fill_start,
  input  logic                                readout_pause,
  input  logic                                link_up,
  output logic                                reading_done,
  output logic                                red_led,
  output logic                                green_led
);
  import readout_pkg::*;

  logic [burst_width-1:0] fifo_rd_data;   // head burst to the converter
  logic                   fifo_rd_last;
  logic                   fifo_rd_valid;
  logic                   fifo_rd_ready;
  logic [link_width-1:0]  fill_data;      // 32-bit fill words to the mux
  logic                   fill_valid;
  logic                   fill_last;
  logic                   fill_ready;
  logic                   use_fill_data;  // link source select
  logic                   cmd_accept;
  logic                   fill_accept;
  logic                   accept_last;
  logic                   fill_busy;

  //////////////////////////////////////////////////////////////////////
  // fill data path
  //////////////////////////////////////////////////////////////////////

  burst_fifo #(
    .fifo_depth        (fifo_depth),
    .almost_full_level (almost_full_level)
  ) fifo_i (
    .clk125      (clk125),
    .rst_n       (rst_n),
    .wr_data     (mem_data),
    .wr_last     (mem_last),
    .wr_en       (mem_valid),
    .rd_ready    (fifo_rd_ready),
    .rd_data     (fifo_rd_data),
    .rd_last     (fifo_rd_last),
    .rd_valid    (fifo_rd_valid),
    .almost_full (mem_almost_full)
  );

  burst_width_converter conv_i (
    .clk125      (clk125),
    .rst_n       (rst_n),
    .burst_data  (fifo_rd_data),
    .burst_last  (fifo_rd_last),
    .burst_valid (fifo_rd_valid),
    .word_ready  (fill_ready),
    .burst_ready (fifo_rd_ready),
    .word_data   (fill_data),
    .word_last   (fill_last),
    .word_valid  (fill_valid)
  );

  //////////////////////////////////////////////////////////////////////
  // link arbitration and status
  //////////////////////////////////////////////////////////////////////

  link_tx_mux mux_i (
    .clk125        (clk125),
    .rst_n         (rst_n),
    .readout_pause (readout_pause),
    .use_fill_data (use_fill_data),
    .cmd_data      (cmd_data),
    .cmd_valid     (cmd_valid),
    .cmd_last      (cmd_last),
    .fill_data     (fill_data),
    .fill_valid    (fill_valid),
    .fill_last     (fill_last),
    .tx_ready      (tx_ready),
    .cmd_ready     (cmd_ready),
    .fill_ready    (fill_ready),
    .tx_data       (tx_data),
    .tx_valid      (tx_valid),
    .tx_last       (tx_last),
    .cmd_accept    (cmd_accept),
    .fill_accept   (fill_accept),
    .accept_last   (accept_last)
  );

  fill_readout_ctrl ctrl_i (
    .clk125        (clk125),
    .rst_n         (rst_n),
    .fill_start    (fill_start),
    .cmd_accept    (cmd_accept),
    .fill_accept   (fill_accept),
    .accept_last   (accept_last),
    .use_fill_data (use_fill_data),
    .reading_done  (reading_done),
    .fill_busy     (fill_busy)
  );

  status_led #(
    .blink_bit (blink_bit)
  ) led_i (
    .clk125    (clk125),
    .rst_n     (rst_n),
    .link_up   (link_up),
    .fill_busy (fill_busy),
    .red_led   (red_led),
    .green_led (green_led)
  );

endmodule

/* verification/channel_readout_checker.sv */
`timescale 1ns/1ps

module channel_readout_checker (
  input logic                               clk125,
  input logic                               rst_n,
  input logic                               mem_valid,      // burst write strobe
  input logic                               fifo_full,      // burst fifo has no free entry
  input logic [readout_pkg::link_width-1:0] tx_data,
  input logic                               tx_valid,
  input logic                               tx_last,
  input logic                               tx_ready,
  input logic                               pause_sync,     // pause after the synchronizer
  input logic                               use_fill_data,  // link source select
  input readout_pkg::fill_state_e           ctrl_state      // controller state
);
  import readout_pkg::*;

  int   assert_failures = 0;   // failed assertion count, read by the testbench
  logic frame_open;            // a link frame started and has not seen last

  always_ff @(posedge clk125) begin
    if (!rst_n) begin
      frame_open <= 1'b0;
    end else if (tx_valid && tx_ready) begin
      frame_open <= !tx_last;  // open after any beat but the last
    end
  end

  //////////////////////////////////////////////////////////////////////
  // fifo and link properties
  //////////////////////////////////////////////////////////////////////

  no_write_when_full: assert property (
    @(posedge clk125) disable iff (!rst_n) mem_valid |-> !fifo_full
  ) else begin
    $error("burst written while the fifo was full");
    assert_failures++;
  end

  // a pending beat stays put unless the pause hides it or the source switches
  tx_held_until_taken: assert property (
    @(posedge clk125) disable iff (!rst_n)
    (tx_valid && !tx_ready) |=> !$stable(use_fill_data) ||
      ((tx_valid || pause_sync) && $stable(tx_data) && $stable(tx_last))
  ) else begin
    $error("tx beat changed or vanished before it was accepted");
    assert_failures++;
  end

  source_fixed_in_frame: assert property (
    @(posedge clk125) disable iff (!rst_n) frame_open |-> $stable(use_fill_data)
  ) else begin
    $error("link source switched inside a frame");
    assert_failures++;
  end

  // fill_send only ends with the fill's last word taken by the link
  fill_ends_on_last: assert property (
    @(posedge clk125) disable iff (!rst_n)
    (ctrl_state == fill_send) && !(tx_valid && tx_ready && tx_last)
      |=> ctrl_state == fill_send
  ) else begin
    $error("fill controller left fill_send before the last fill word");
    assert_failures++;
  end

endmodule

bind channel_readout_top channel_readout_checker checker_i (
  .clk125        (clk125),
  .rst_n         (rst_n),
  .mem_valid     (mem_valid),
  .fifo_full     (fifo_i.full),
  .tx_data       (tx_data),
  .tx_valid      (tx_valid),
  .tx_last       (tx_last),
  .tx_ready      (tx_ready),
  .pause_sync    (mux_i.pause_s2),
  .use_fill_data (use_fill_data),
  .ctrl_state    (ctrl_i.state)
);

/* verification/channel_readout_tb.sv */
`timescale 1ns/1ps

module channel_readout_tb;
  import readout_pkg::*;

  localparam logic [31:0] seed           = 32'h66029b26;
  localparam int          num_fills      = 20;
  localparam int          num_cmd_frames = 30;
  localparam int          wait_limit     = 5000;     // cycles allowed per wait
  localparam int          run_limit      = 200000;   // cycles allowed for all traffic

  logic                   clk125;
  logic                   rst_n;
  logic [burst_width-1:0] mem_data;
  logic                   mem_valid;
  logic                   mem_last;
  logic                   mem_almost_full;
  logic [link_width-1:0]  cmd_data;
  logic                   cmd_valid;
  logic                   cmd_last;
  logic                   cmd_ready;
  logic [link_width-1:0]  tx_data;
  logic                   tx_valid;
  logic                   tx_last;
  logic                   tx_ready;
  logic                   fill_start;
  logic                   readout_pause;
  logic                   link_up;
  logic                   reading_done;
  logic                   red_led;
  logic                   green_led;

  logic [link_width-1:0]  fill_words [$];   // expected fill frames back to back
  logic                   fill_lasts [$];
  logic [link_width-1:0]  cmd_words [$];    // expected command frames back to back
  logic                   cmd_lasts [$];
  int                     done_cnt        = 0;  // reading_done pulses seen
  int                     fills_requested = 0;  // fill_start pulses driven
  int                     green_rises     = 0;  // green rising edges while a fill is open
  int                     streams_done    = 0;  // stimulus tasks finished

  channel_readout_top #(.blink_bit(3)) dut_i (.*);

  initial begin
    clk125 = 1'b0;
    forever #5 clk125 = ~clk125;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("ERROR %s expected %h got %h", name, expected, actual));
    end
  endtask

  task automatic wait_mem_space();
    int t;
    t = 0;
    forever begin
      @(negedge clk125);
      if (!mem_almost_full) break;
      t++;
      if (t > wait_limit) fail_run("mem_almost_full stayed high too long");
      @(posedge clk125);
      mem_valid <= 1'b0;                 // hold off while the fifo is nearly full
    end
    @(posedge clk125);
  endtask

  task automatic wait_cmd_accept();
    int t;
    t = 0;
    forever begin
      @(negedge clk125);
      if (cmd_ready) break;              // valid is high, beat goes at the next edge
      t++;
      if (t > wait_limit) fail_run("a command beat was never accepted");
      @(posedge clk125);
    end
    @(posedge clk125);
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic write_fills();
    logic [31:0]            rs;
    logic [31:0]            r;
    logic [burst_width-1:0] burst;
    logic [link_width-1:0]  word;
    int                     f;
    int                     b;
    int                     w;
    int                     nb;
    rs = seed ^ 32'h0000_0001;
    for (f = 0; f < num_fills; f++) begin
      r = lcg_next(rs);
      nb = (f == 0) ? 4 : 1 + int'(r[31:30]);  // first fill long enough to blink
      for (b = 0; b < nb; b++) begin
        for (w = 0; w < words_per_burst; w++) begin
          r = lcg_next(rs);
          word = {1'b1, r[31:1]};              // top bit set marks fill words
          burst[w*link_width +: link_width] = word;
          fill_words.push_back(word);          // lsw leaves first
          fill_lasts.push_back((b == nb - 1) && (w == words_per_burst - 1));
        end
        wait_mem_space();
        mem_data  <= burst;
        mem_last  <= (b == nb - 1);
        mem_valid <= 1'b1;
      end
    end
    @(posedge clk125);
    mem_valid <= 1'b0;
  endtask

  task automatic request_fills();
    logic [31:0] rs;
    logic [31:0] r;
    int          f;
    int          t;
    rs = seed ^ 32'h0000_0003;
    for (f = 0; f < num_fills; f++) begin
      r = lcg_next(rs);
      repeat (r[31:28]) @(posedge clk125);   // random spacing
      @(posedge clk125);
      fill_start <= 1'b1;
      fills_requested++;
      @(posedge clk125);
      fill_start <= 1'b0;
      t = 0;
      while (done_cnt < f + 1) begin
        @(posedge clk125);
        t++;
        if (t > wait_limit) fail_run($sformatf("reading_done never came for fill %0d", f));
      end
    end
  endtask

  task automatic send_commands();
    logic [31:0]           rs;
    logic [31:0]           r;
    logic [link_width-1:0] beat [5];
    int                    f;
    int                    i;
    int                    len;
    rs = seed ^ 32'h0000_0002;
    @(posedge clk125);
    for (f = 0; f < num_cmd_frames; f++) begin
      r = lcg_next(rs);
      len = 1 + int'(r[31:28]) % 5;
      for (i = 0; i < len; i++) begin
        r = lcg_next(rs);
        beat[i] = {1'b0, r[31:1]};           // top bit clear marks command words
        cmd_words.push_back(beat[i]);
        cmd_lasts.push_back(i == len - 1);
      end
      for (i = 0; i < len; i++) begin
        r = lcg_next(rs);
        if (r[31:30] != 2'd0) begin
          cmd_valid <= 1'b0;                 // idle gap before this beat
          repeat (r[31:30]) @(posedge clk125);
        end
        cmd_data  <= beat[i];
        cmd_last  <= (i == len - 1);
        cmd_valid <= 1'b1;
        wait_cmd_accept();
      end
    end
    cmd_valid <= 1'b0;
    cmd_last  <= 1'b0;
  endtask

  task automatic drive_link();
    logic [31:0] rs;
    logic [31:0] r;
    int          hold;
    int          cycles;
    rs     = seed ^ 32'h0000_0004;
    hold   = 0;
    cycles = 0;
    while (streams_done < 3) begin
      @(posedge clk125);
      cycles++;
      if (cycles > run_limit) fail_run("traffic did not finish within the run limit");
      r = lcg_next(rs);
      tx_ready <= (r[31:30] != 2'd0);        // ready three cycles in four
      if (hold > 0) begin
        hold--;
        if (hold == 0) readout_pause <= 1'b0;
      end else if (r[29:25] == 5'd0) begin
        readout_pause <= 1'b1;               // pause episode
        hold = 6 + int'(r[24:21]);
      end
    end
    readout_pause <= 1'b0;
    tx_ready      <= 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // link monitor and reference model
  //////////////////////////////////////////////////////////////////////

  initial begin : link_monitor
    logic                  in_frame;
    logic                  frame_is_fill;
    logic                  fill_end_seen;    // fill last taken, done due next cycle
    logic                  green_prev;
    logic [link_width-1:0] exp_word;
    logic                  exp_last;
    int                    pause_cnt;
    in_frame      = 1'b0;
    frame_is_fill = 1'b0;
    fill_end_seen = 1'b0;
    green_prev    = 1'b0;
    pause_cnt     = 0;
    forever begin
      @(negedge clk125);
      if (dut_i.checker_i.assert_failures != 0) fail_run("a bound assertion failed");
      if (rst_n) begin
        compare_value("reading_done", fill_end_seen, reading_done);
        if (reading_done) done_cnt++;
        fill_end_seen = 1'b0;
        pause_cnt = readout_pause ? pause_cnt + 1 : 0;
        if (pause_cnt >= 3) compare_value("tx_valid", 0, tx_valid);  // sync depth passed
        if (green_led && !green_prev && (fills_requested > done_cnt)) begin
          green_rises++;                     // blink edge while a fill is open
        end
        green_prev = green_led;
        if (tx_valid && tx_ready) begin
          if (!in_frame) frame_is_fill = tx_data[link_width-1];  // tag picks the stream
          if (frame_is_fill) begin
            if (fill_words.size() == 0) fail_run("fill word on the link that was never written");
            exp_word = fill_words.pop_front();
            exp_last = fill_lasts.pop_front();
          end else begin
            if (cmd_words.size() == 0) fail_run("command word on the link that was never sent");
            exp_word = cmd_words.pop_front();
            exp_last = cmd_lasts.pop_front();
          end
          compare_value("tx_data", exp_word, tx_data);
          compare_value("tx_last", exp_last, tx_last);
          in_frame      = !tx_last;
          fill_end_seen = frame_is_fill && tx_last;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main_sequence
    rst_n         = 1'b0;
    mem_data      = '0;
    mem_valid     = 1'b0;
    mem_last      = 1'b0;
    cmd_data      = '0;
    cmd_valid     = 1'b0;
    cmd_last      = 1'b0;
    tx_ready      = 1'b1;                      // link ready, the reset pause must hold off
    fill_start    = 1'b0;
    readout_pause = 1'b0;
    link_up       = 1'b0;
    repeat (2) @(posedge clk125);
    rst_n <= 1'b1;
    @(negedge clk125);
    compare_value("tx_valid", 0, tx_valid);
    compare_value("cmd_ready", 0, cmd_ready);
    compare_value("mem_almost_full", 0, mem_almost_full);
    compare_value("reading_done", 0, reading_done);
    repeat (2) @(negedge clk125);
    compare_value("red_led", 1, red_led);      // link down
    compare_value("green_led", 0, green_led);
    @(posedge clk125);
    link_up <= 1'b1;
    repeat (3) @(negedge clk125);
    compare_value("red_led", 0, red_led);      // link up, no readout
    compare_value("green_led", 1, green_led);
    @(posedge clk125);
    green_rises = 0;
    fork
      begin
        write_fills();
        streams_done++;
      end
      begin
        request_fills();
        streams_done++;
      end
      begin
        send_commands();
        streams_done++;
      end
      drive_link();
    join
    compare_value("fill words left", 0, fill_words.size());
    compare_value("command words left", 0, cmd_words.size());
    compare_value("reading_done pulses", num_fills, done_cnt);
    compare_value("green_led blinked", 1, green_rises > 0);
    repeat (3) @(negedge clk125);
    compare_value("green_led", 1, green_led);  // steady again once idle
    if (dut_i.checker_i.assert_failures == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      fail_run("a bound assertion failed");
    end
  end

endmodule

/* all.f */
hw/readout_pkg.sv
hw/burst_fifo.sv
hw/burst_width_converter.sv
hw/fill_readout_ctrl.sv
hw/link_tx_mux.sv
hw/status_led.sv
hw/channel_readout_top.sv
verification/channel_readout_checker.sv
verification/channel_readout_tb.sv
